/* design/coproc_pkg.sv */
// Slot-memory coprocessor shared types, instruction encoding and slot sizing

`default_nettype none

package coproc_pkg;

  localparam int SLOT_ADDR_BITS = 8;
  localparam int INST_ADDR_BITS = 8;
  // Interrupt header is index (16 bits) plus type byte
  localparam int IRQ_HDR_BITS = 24;

  typedef enum logic [3:0] {
    NOOP_WAIT      = 4'h0,
    COPY_REG       = 4'h1,
    MUL_ELEMENT    = 4'h2,
    SEND_INTERRUPT = 4'h6
  } code_t;

  typedef enum logic [1:0] {
    SCALAR = 2'd0,
    FE     = 2'd1,
    FE2    = 2'd2,
    FP_AF  = 2'd3
  } slot_type_t;

  // Multi-word values occupy consecutive slots
  function automatic logic [1:0] slot_words(slot_type_t t);
    return (t == FE2 || t == FP_AF) ? 2'd2 : 2'd1;
  endfunction

  // Interrupt FIFO entry must hold a header or a data word
  function automatic int irq_word_bits(int dat_bits);
    return (dat_bits > IRQ_HDR_BITS) ? dat_bits : IRQ_HDR_BITS;
  endfunction

  // Operand field, three slot addresses or slot plus interrupt index
  typedef union packed {
    struct packed {
      logic [SLOT_ADDR_BITS-1:0] a;
      logic [SLOT_ADDR_BITS-1:0] b;
      logic [SLOT_ADDR_BITS-1:0] c;
    } addr;
    struct packed {
      logic [SLOT_ADDR_BITS-1:0] a;
      logic [15:0]               idx;
    } irq;
  } inst_args_t;

  typedef struct packed {
    code_t      code;
    inst_args_t args;
  } inst_t;

endpackage

`default_nettype wire

/* design/inst_fetch.sv */
// Instruction fetch with instruction RAM, pointer and halt on NOOP_WAIT

`default_nettype none

module inst_fetch
  import coproc_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_inst_we,
  input  logic [INST_ADDR_BITS-1:0] i_inst_addr,
  input  inst_t                     i_inst_wdat,
  input  logic                      i_start,
  input  logic [INST_ADDR_BITS-1:0] i_start_pt,
  input  logic                      i_inst_done,
  output inst_t                     o_inst,
  output logic                      o_inst_val,
  output logic                      o_halted
);

  inst_t                     inst_ram [2**INST_ADDR_BITS];
  inst_t                     inst_q;
  logic [INST_ADDR_BITS-1:0] ip;
  logic [INST_ADDR_BITS-1:0] ip_next;

  assign ip_next = ip + 1'b1;
  assign o_inst  = inst_q;

  // Registered read, next word lands as the current one retires
  always_ff @(posedge i_clk) begin
    if (i_inst_we)
      inst_ram[i_inst_addr] <= i_inst_wdat;
    if (i_start)
      inst_q <= inst_ram[i_start_pt];
    else if (i_inst_done)
      inst_q <= inst_ram[ip_next];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ip         <= '0;
      o_inst_val <= 1'b0;
      o_halted   <= 1'b1;
    end else if (i_start) begin
      ip         <= i_start_pt;
      o_inst_val <= 1'b1;
      o_halted   <= 1'b0;
    end else if (o_inst_val && inst_q.code == NOOP_WAIT) begin
      // Stop here, execute never retires a NOOP_WAIT
      o_inst_val <= 1'b0;
      o_halted   <= 1'b1;
    end else if (i_inst_done) begin
      ip <= ip_next;
    end
  end

  // Execute only retires what fetch is presenting
  a_done_with_val: assert property (@(posedge i_clk) disable iff (i_rst)
    i_inst_done |-> o_inst_val);

endmodule

`default_nettype wire

/* design/slot_ram.sv */
// Dual-port slot RAM holding a type and a data word per slot

`default_nettype none

module slot_ram
  import coproc_pkg::*;
#(
  parameter int DAT_BITS = 16
) (
  input  logic                      i_clk,
  // Port A, execute side
  input  logic [SLOT_ADDR_BITS-1:0] i_a_addr,
  input  logic                      i_a_we,
  input  slot_type_t                i_a_wtype,
  input  logic [DAT_BITS-1:0]       i_a_wdat,
  output slot_type_t                o_a_rtype,
  output logic [DAT_BITS-1:0]       o_a_rdat,
  // Port B, user side
  input  logic [SLOT_ADDR_BITS-1:0] i_b_addr,
  input  logic                      i_b_we,
  input  slot_type_t                i_b_wtype,
  input  logic [DAT_BITS-1:0]       i_b_wdat,
  output slot_type_t                o_b_rtype,
  output logic [DAT_BITS-1:0]       o_b_rdat
);

  slot_type_t          type_mem [2**SLOT_ADDR_BITS];
  logic [DAT_BITS-1:0] dat_mem  [2**SLOT_ADDR_BITS];

  always_ff @(posedge i_clk) begin
    if (i_a_we) begin
      type_mem[i_a_addr] <= i_a_wtype;
      dat_mem[i_a_addr]  <= i_a_wdat;
    end
    if (i_b_we) begin
      type_mem[i_b_addr] <= i_b_wtype;
      dat_mem[i_b_addr]  <= i_b_wdat;
    end
    // Read first on both ports
    o_a_rtype <= type_mem[i_a_addr];
    o_a_rdat  <= dat_mem[i_a_addr];
    o_b_rtype <= type_mem[i_b_addr];
    o_b_rdat  <= dat_mem[i_b_addr];
  end

endmodule

`default_nettype wire

/* design/inst_exec.sv */
// Instruction execute stage with operand reads, multiply issue, write-back and interrupt feed

`default_nettype none

module inst_exec
  import coproc_pkg::*;
#(
  parameter int DAT_BITS = 16
) (
  input  logic                               i_clk,
  input  logic                               i_rst,
  // Fetch
  input  inst_t                              i_inst,
  input  logic                               i_inst_val,
  input  logic                               i_halted,
  output logic                               o_inst_done,
  // Slot RAM
  output logic [SLOT_ADDR_BITS-1:0]          o_ram_addr,
  output logic                               o_ram_we,
  output slot_type_t                         o_ram_wtype,
  output logic [DAT_BITS-1:0]                o_ram_wdat,
  input  slot_type_t                         i_ram_rtype,
  input  logic [DAT_BITS-1:0]                i_ram_rdat,
  // Multiplier
  output logic                               o_mul_val,
  output logic [DAT_BITS-1:0]                o_mul_a,
  output logic [DAT_BITS-1:0]                o_mul_b,
  output logic [SLOT_ADDR_BITS-1:0]          o_mul_tag,
  output slot_type_t                         o_mul_type,
  input  logic                               i_mul_val,
  input  logic [DAT_BITS-1:0]                i_mul_dat,
  input  logic [SLOT_ADDR_BITS-1:0]          i_mul_tag,
  input  slot_type_t                         i_mul_type,
  // Interrupt FIFO
  output logic                               o_irq_push,
  output logic                               o_irq_hdr,
  output logic [irq_word_bits(DAT_BITS)-1:0] o_irq_dat,
  output logic                               o_irq_last,
  input  logic                               i_irq_space,
  output logic                               o_busy
);

  localparam int IB = irq_word_bits(DAT_BITS);

  inst_args_t                  args;
  logic [2:0]                  step;
  logic [2:0]                  step_nxt;
  logic [DAT_BITS-1:0]         op_a;
  slot_type_t                  op_type;
  logic [1:0]                  words_left;
  logic [SLOT_ADDR_BITS-1:0]   rd_addr;
  logic [SLOT_ADDR_BITS-1:0]   seq_addr;
  logic                        seq_we;
  logic [2**SLOT_ADDR_BITS-1:0] pending;
  logic [SLOT_ADDR_BITS:0]     inflight;
  logic                        src_busy;

  assign args     = i_inst.args;
  // Destination counts too, so each slot has at most one result in flight
  assign src_busy = pending[args.addr.a] || pending[args.addr.b] || pending[args.addr.c];

  always_comb begin
    step_nxt    = step;
    seq_addr    = args.addr.a;
    seq_we      = 1'b0;
    o_inst_done = 1'b0;
    o_mul_val   = 1'b0;
    o_irq_push  = 1'b0;
    o_irq_hdr   = 1'b0;
    o_irq_last  = 1'b0;
    o_irq_dat   = IB'(i_ram_rdat);
    if (i_inst_val) begin
      case (i_inst.code)
        NOOP_WAIT: o_inst_done = 1'b0;
        COPY_REG: begin
          if (step == 3'd0) begin
            if (inflight == '0)
              step_nxt = 3'd1;
          end else begin
            seq_we      = 1'b1;
            seq_addr    = args.addr.b;
            o_inst_done = 1'b1;
            step_nxt    = 3'd0;
          end
        end
        MUL_ELEMENT: begin
          case (step)
            3'd0: if (!src_busy && !i_mul_val) step_nxt = 3'd1;
            3'd1, 3'd2: begin
              seq_addr = args.addr.b;
              step_nxt = i_mul_val ? 3'd2 : 3'd3;
            end
            default: begin
              o_mul_val   = 1'b1;
              o_inst_done = 1'b1;
              step_nxt    = 3'd0;
            end
          endcase
        end
        SEND_INTERRUPT: begin
          case (step)
            3'd0: if (inflight == '0) step_nxt = 3'd1;
            3'd1: step_nxt = 3'd2;
            3'd2: begin
              // Header bytes go out as index low, index high, type
              o_irq_dat = IB'({6'd0, op_type, args.irq.idx});
              o_irq_hdr = 1'b1;
              if (i_irq_space) begin
                o_irq_push = 1'b1;
                step_nxt   = 3'd3;
              end
            end
            3'd3: begin
              seq_addr = rd_addr;
              if (i_irq_space)
                step_nxt = 3'd4;
            end
            default: begin
              // Space was seen on the read cycle and only pops happened since
              o_irq_push = 1'b1;
              o_irq_last = (words_left == 2'd1);
              if (o_irq_last) begin
                o_inst_done = 1'b1;
                step_nxt    = 3'd0;
              end else begin
                step_nxt = 3'd3;
              end
            end
          endcase
        end
        default: o_inst_done = 1'b1;
      endcase
    end
  end

  // Multiplier write-back owns the port when present
  assign o_ram_we    = i_mul_val || seq_we;
  assign o_ram_addr  = i_mul_val ? i_mul_tag : seq_addr;
  assign o_ram_wdat  = i_mul_val ? i_mul_dat : i_ram_rdat;
  assign o_ram_wtype = i_mul_val ? i_mul_type : i_ram_rtype;

  assign o_mul_a    = op_a;
  assign o_mul_b    = i_ram_rdat;
  assign o_mul_tag  = args.addr.c;
  assign o_mul_type = op_type;

  assign o_busy = !i_halted || inflight != '0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      step     <= 3'd0;
      pending  <= '0;
      inflight <= '0;
    end else begin
      step <= step_nxt;
      if (i_mul_val)
        pending[i_mul_tag] <= 1'b0;
      if (o_mul_val)
        pending[args.addr.c] <= 1'b1;
      inflight <= inflight + (SLOT_ADDR_BITS + 1)'(o_mul_val)
                           - (SLOT_ADDR_BITS + 1)'(i_mul_val);
    end
  end

  // Slot a comes back in step 1 for every instruction that reads it
  always_ff @(posedge i_clk) begin
    if (step == 3'd1) begin
      op_a       <= i_ram_rdat;
      op_type    <= i_ram_rtype;
      words_left <= slot_words(i_ram_rtype);
      rd_addr    <= args.addr.a;
    end else if (step == 3'd4) begin
      words_left <= words_left - 2'd1;
      rd_addr    <= rd_addr + 1'b1;
    end
  end

  a_one_write: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_mul_val && seq_we));

  // Every returning result targets a slot marked pending at issue
  a_wb_pending: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_val |-> pending[i_mul_tag]);

endmodule

`default_nettype wire

/* design/mod_mult.sv */
// Fixed-latency modular multiplier carrying a destination tag and slot type

`default_nettype none

module mod_mult
  import coproc_pkg::*;
#(
  parameter int          DAT_BITS   = 16,
  parameter int unsigned P          = 65521,
  parameter int          MUL_STAGES = 3
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_val,
  input  logic [DAT_BITS-1:0]       i_a,
  input  logic [DAT_BITS-1:0]       i_b,
  input  logic [SLOT_ADDR_BITS-1:0] i_tag,
  input  slot_type_t                i_type,
  output logic                      o_val,
  output logic [DAT_BITS-1:0]       o_dat,
  output logic [SLOT_ADDR_BITS-1:0] o_tag,
  output slot_type_t                o_type
);

  logic [2*DAT_BITS-1:0]     prod;
  logic [DAT_BITS-1:0]       dat_pipe  [MUL_STAGES];
  logic [SLOT_ADDR_BITS-1:0] tag_pipe  [MUL_STAGES];
  slot_type_t                type_pipe [MUL_STAGES];
  logic [MUL_STAGES-1:0]     val_pipe;

  // Operands are already reduced, so the remainder fits a word
  assign prod = i_a * i_b;

  always_ff @(posedge i_clk) begin
    dat_pipe[0]  <= DAT_BITS'(prod % P);
    tag_pipe[0]  <= i_tag;
    type_pipe[0] <= i_type;
    for (int i = 1; i < MUL_STAGES; i++) begin
      dat_pipe[i]  <= dat_pipe[i-1];
      tag_pipe[i]  <= tag_pipe[i-1];
      type_pipe[i] <= type_pipe[i-1];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst)
      val_pipe <= '0;
    else
      val_pipe <= MUL_STAGES'({val_pipe, i_val});
  end

  assign o_val  = val_pipe[MUL_STAGES-1];
  assign o_dat  = dat_pipe[MUL_STAGES-1];
  assign o_tag  = tag_pipe[MUL_STAGES-1];
  assign o_type = type_pipe[MUL_STAGES-1];

endmodule

`default_nettype wire

/* design/irq_tx.sv */
// Interrupt FIFO and byte serializer for header and slot words

`default_nettype none

module irq_tx
  import coproc_pkg::*;
#(
  parameter int DAT_BITS  = 16,
  parameter int IRQ_DEPTH = 8
) (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic                               i_push,
  input  logic                               i_hdr,
  input  logic [irq_word_bits(DAT_BITS)-1:0] i_dat,
  input  logic                               i_last,
  input  logic                               i_tx_rdy,
  output logic                               o_space,
  output logic                               o_tx_val,
  output logic [7:0]                         o_tx_dat,
  output logic                               o_tx_sop,
  output logic                               o_tx_eop
);

  localparam int IB       = irq_word_bits(DAT_BITS);
  localparam int AW       = $clog2(IRQ_DEPTH);
  localparam int DAT_BYTS = DAT_BITS / 8;
  localparam int LW       = $clog2(IB / 8 + 1);

  // Entry is {hdr, last, data}
  logic [IB+1:0]   fifo [IRQ_DEPTH];
  logic [AW:0]     wr_ptr;
  logic [AW:0]     rd_ptr;
  logic            full;
  logic            empty;
  logic            ent_hdr;
  logic            ent_last;
  logic [IB-1:0]   ent_dat;
  logic [LW-1:0]   ent_byts;
  logic [IB-1:0]   sh;
  logic [LW-1:0]   left;
  logic            cur_last;
  logic            adv;
  logic            pop;

  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty   = (wr_ptr == rd_ptr);
  assign o_space = !full;

  assign {ent_hdr, ent_last, ent_dat} = fifo[rd_ptr[AW-1:0]];
  assign ent_byts = ent_hdr ? LW'(3) : LW'(DAT_BYTS);

  // Output register moves when empty or taken
  assign adv = !o_tx_val || i_tx_rdy;
  assign pop = adv && left == '0 && !empty;

  always_ff @(posedge i_clk) begin
    if (i_push)
      fifo[wr_ptr[AW-1:0]] <= {i_hdr, i_last, i_dat};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      left     <= '0;
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
    end else begin
      if (i_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (adv) begin
        if (left != '0) begin
          o_tx_val <= 1'b1;
          o_tx_sop <= 1'b0;
          o_tx_eop <= cur_last && left == LW'(1);
          left     <= left - 1'b1;
        end else if (!empty) begin
          // First byte of a new entry goes straight out
          o_tx_val <= 1'b1;
          o_tx_sop <= ent_hdr;
          o_tx_eop <= ent_last && ent_byts == LW'(1);
          left     <= ent_byts - 1'b1;
        end else begin
          o_tx_val <= 1'b0;
        end
      end
    end
  end

  // Least significant byte first
  always_ff @(posedge i_clk) begin
    if (adv) begin
      if (left != '0) begin
        o_tx_dat <= sh[7:0];
        sh       <= sh >> 8;
      end else if (!empty) begin
        o_tx_dat <= ent_dat[7:0];
        sh       <= ent_dat >> 8;
        cur_last <= ent_last;
      end
    end
  end

  // Execute must check space before every push
  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
    i_push |-> o_space);

endmodule

`default_nettype wire

/* design/coproc_top.sv */
// Coprocessor top level joining fetch, execute, slot RAM, multiplier and interrupt transmit

`default_nettype none

module coproc_top
  import coproc_pkg::*;
#(
  parameter int          DAT_BITS   = 16,
  parameter int unsigned P          = 65521,
  parameter int          MUL_STAGES = 3,
  parameter int          IRQ_DEPTH  = 8
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  // Instruction load
  input  logic                      i_inst_we,
  input  logic [INST_ADDR_BITS-1:0] i_inst_addr,
  input  inst_t                     i_inst_wdat,
  // User slot access
  input  logic                      i_slot_we,
  input  logic [SLOT_ADDR_BITS-1:0] i_slot_addr,
  input  slot_type_t                i_slot_wtype,
  input  logic [DAT_BITS-1:0]       i_slot_wdat,
  output slot_type_t                o_slot_rtype,
  output logic [DAT_BITS-1:0]       o_slot_rdat,
  // Program start
  input  logic                      i_start,
  input  logic [INST_ADDR_BITS-1:0] i_start_pt,
  output logic                      o_busy,
  // Interrupt byte stream
  output logic                      o_tx_val,
  output logic [7:0]                o_tx_dat,
  output logic                      o_tx_sop,
  output logic                      o_tx_eop,
  input  logic                      i_tx_rdy
);

  inst_t                             inst;
  logic                              inst_val;
  logic                              inst_done;
  logic                              halted;

  logic [SLOT_ADDR_BITS-1:0]         ram_addr;
  logic                              ram_we;
  slot_type_t                        ram_wtype;
  logic [DAT_BITS-1:0]               ram_wdat;
  slot_type_t                        ram_rtype;
  logic [DAT_BITS-1:0]               ram_rdat;

  logic                              mul_val;
  logic [DAT_BITS-1:0]               mul_a;
  logic [DAT_BITS-1:0]               mul_b;
  logic [SLOT_ADDR_BITS-1:0]         mul_tag;
  slot_type_t                        mul_type;
  logic                              res_val;
  logic [DAT_BITS-1:0]               res_dat;
  logic [SLOT_ADDR_BITS-1:0]         res_tag;
  slot_type_t                        res_type;

  logic                              irq_push;
  logic                              irq_hdr;
  logic [irq_word_bits(DAT_BITS)-1:0] irq_dat;
  logic                              irq_last;
  logic                              irq_space;

  // A start while running is ignored
  inst_fetch u_fetch (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_inst_we   (i_inst_we),
    .i_inst_addr (i_inst_addr),
    .i_inst_wdat (i_inst_wdat),
    .i_start     (i_start && !o_busy),
    .i_start_pt  (i_start_pt),
    .i_inst_done (inst_done),
    .o_inst      (inst),
    .o_inst_val  (inst_val),
    .o_halted    (halted)
  );

  slot_ram #(.DAT_BITS(DAT_BITS)) u_slot_ram (
    .i_clk     (i_clk),
    .i_a_addr  (ram_addr),
    .i_a_we    (ram_we),
    .i_a_wtype (ram_wtype),
    .i_a_wdat  (ram_wdat),
    .o_a_rtype (ram_rtype),
    .o_a_rdat  (ram_rdat),
    .i_b_addr  (i_slot_addr),
    .i_b_we    (i_slot_we),
    .i_b_wtype (i_slot_wtype),
    .i_b_wdat  (i_slot_wdat),
    .o_b_rtype (o_slot_rtype),
    .o_b_rdat  (o_slot_rdat)
  );

  inst_exec #(.DAT_BITS(DAT_BITS)) u_exec (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_inst      (inst),
    .i_inst_val  (inst_val),
    .i_halted    (halted),
    .o_inst_done (inst_done),
    .o_ram_addr  (ram_addr),
    .o_ram_we    (ram_we),
    .o_ram_wtype (ram_wtype),
    .o_ram_wdat  (ram_wdat),
    .i_ram_rtype (ram_rtype),
    .i_ram_rdat  (ram_rdat),
    .o_mul_val   (mul_val),
    .o_mul_a     (mul_a),
    .o_mul_b     (mul_b),
    .o_mul_tag   (mul_tag),
    .o_mul_type  (mul_type),
    .i_mul_val   (res_val),
    .i_mul_dat   (res_dat),
    .i_mul_tag   (res_tag),
    .i_mul_type  (res_type),
    .o_irq_push  (irq_push),
    .o_irq_hdr   (irq_hdr),
    .o_irq_dat   (irq_dat),
    .o_irq_last  (irq_last),
    .i_irq_space (irq_space),
    .o_busy      (o_busy)
  );

  mod_mult #(
    .DAT_BITS   (DAT_BITS),
    .P          (P),
    .MUL_STAGES (MUL_STAGES)
  ) u_mult (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_val  (mul_val),
    .i_a    (mul_a),
    .i_b    (mul_b),
    .i_tag  (mul_tag),
    .i_type (mul_type),
    .o_val  (res_val),
    .o_dat  (res_dat),
    .o_tag  (res_tag),
    .o_type (res_type)
  );

  irq_tx #(
    .DAT_BITS  (DAT_BITS),
    .IRQ_DEPTH (IRQ_DEPTH)
  ) u_irq_tx (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (irq_push),
    .i_hdr    (irq_hdr),
    .i_dat    (irq_dat),
    .i_last   (irq_last),
    .i_tx_rdy (i_tx_rdy),
    .o_space  (irq_space),
    .o_tx_val (o_tx_val),
    .o_tx_dat (o_tx_dat),
    .o_tx_sop (o_tx_sop),
    .o_tx_eop (o_tx_eop)
  );

endmodule

`default_nettype wire

/* testbench/tb_coproc.sv */
// Testbench for the slot-memory coprocessor covering copy, multiply, interrupt stream and restart

`default_nettype none

module tb_coproc
  import coproc_pkg::*;
();

  localparam int          DAT_BITS   = 16;
  localparam int unsigned P          = 65521;
  localparam int          CLK_PERIOD = 100;
  localparam int          N_PROGS    = 4;
  // Cycles allowed per program, loading and readback included
  localparam int          PROG_BOUND = 1500;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_inst_we;
  logic [INST_ADDR_BITS-1:0] i_inst_addr;
  logic [27:0]               i_inst_wdat;
  logic                      i_slot_we;
  logic [SLOT_ADDR_BITS-1:0] i_slot_addr;
  slot_type_t                i_slot_wtype;
  logic [DAT_BITS-1:0]       i_slot_wdat;
  slot_type_t                o_slot_rtype;
  logic [DAT_BITS-1:0]       o_slot_rdat;
  logic                      i_start;
  logic [INST_ADDR_BITS-1:0] i_start_pt;
  logic                      o_busy;
  logic                      o_tx_val;
  logic [7:0]                o_tx_dat;
  logic                      o_tx_sop;
  logic                      o_tx_eop;
  logic                      i_tx_rdy = 1'b0;

  // Reference slot contents
  slot_type_t                m_type [2**SLOT_ADDR_BITS];
  logic [DAT_BITS-1:0]       m_dat  [2**SLOT_ADDR_BITS];
  // Expected stream, each entry is {sop, eop, byte}
  logic [9:0]                exp_tx [512];
  int                        n_exp;
  int                        rx_idx;
  logic [7:0]                exp_byte;
  logic                      exp_sop;
  logic                      exp_eop;
  logic                      rd_chk;
  slot_type_t                exp_type;
  logic [DAT_BITS-1:0]       exp_dat;
  logic                      started;
  logic [INST_ADDR_BITS-1:0] pc;
  integer                    seed = 91987;
  string                     test_name;

  assign exp_byte = exp_tx[rx_idx[8:0]][7:0];
  assign exp_sop  = exp_tx[rx_idx[8:0]][9];
  assign exp_eop  = exp_tx[rx_idx[8:0]][8];

  coproc_top #(
    .DAT_BITS   (DAT_BITS),
    .P          (P),
    .MUL_STAGES (3),
    .IRQ_DEPTH  (8)
  ) DUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_inst_we    (i_inst_we),
    .i_inst_addr  (i_inst_addr),
    .i_inst_wdat  (i_inst_wdat),
    .i_slot_we    (i_slot_we),
    .i_slot_addr  (i_slot_addr),
    .i_slot_wtype (i_slot_wtype),
    .i_slot_wdat  (i_slot_wdat),
    .o_slot_rtype (o_slot_rtype),
    .o_slot_rdat  (o_slot_rdat),
    .i_start      (i_start),
    .i_start_pt   (i_start_pt),
    .o_busy       (o_busy),
    .o_tx_val     (o_tx_val),
    .o_tx_dat     (o_tx_dat),
    .o_tx_sop     (o_tx_sop),
    .o_tx_eop     (o_tx_eop),
    .i_tx_rdy     (i_tx_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    fail_stop($sformatf("ERR %s: %s expected %0h actual %0h", test_name, what, exp, act));
  endtask

  function automatic logic [DAT_BITS-1:0] rand_elem();
    logic [31:0] r;
    r = $random(seed);
    return DAT_BITS'(r % P);
  endfunction

  function automatic slot_type_t rand_type();
    logic [31:0] r;
    r = $random(seed);
    return r[0] ? FE : SCALAR;
  endfunction

  function automatic logic [DAT_BITS-1:0] mul_mod(input logic [DAT_BITS-1:0] a,
                                                  input logic [DAT_BITS-1:0] b);
    logic [2*DAT_BITS-1:0] prod;
    prod = {{DAT_BITS{1'b0}}, a} * {{DAT_BITS{1'b0}}, b};
    return DAT_BITS'(prod % P);
  endfunction

  // FE2 and affine points span two slots
  function automatic int words_of(input slot_type_t t);
    return (t == FE2 || t == FP_AF) ? 2 : 1;
  endfunction

  task automatic write_slot(input int addr, input slot_type_t t, input logic [DAT_BITS-1:0] d);
    @(negedge i_clk);
    i_slot_we    = 1'b1;
    i_slot_addr  = SLOT_ADDR_BITS'(addr);
    i_slot_wtype = t;
    i_slot_wdat  = d;
    @(negedge i_clk);
    i_slot_we    = 1'b0;
    m_type[addr] = t;
    m_dat[addr]  = d;
  endtask

  task automatic put_inst(input logic [27:0] w);
    @(negedge i_clk);
    i_inst_we   = 1'b1;
    i_inst_addr = pc;
    i_inst_wdat = w;
    @(negedge i_clk);
    i_inst_we   = 1'b0;
    pc          = pc + 8'd1;
  endtask

  task automatic push_byte(input logic [7:0] b, input logic sop, input logic eop);
    exp_tx[n_exp] = {sop, eop, b};
    n_exp         = n_exp + 1;
  endtask

  // Each add task also applies the instruction to the reference slots
  task automatic add_copy(input int a, input int b);
    put_inst({COPY_REG, 8'(a), 8'(b), 8'd0});
    m_type[b] = m_type[a];
    m_dat[b]  = m_dat[a];
  endtask

  task automatic add_mul(input int a, input int b, input int c);
    put_inst({MUL_ELEMENT, 8'(a), 8'(b), 8'(c)});
    m_dat[c]  = mul_mod(m_dat[a], m_dat[b]);
    m_type[c] = m_type[a];
  endtask

  task automatic add_send(input int a, input logic [15:0] idx);
    logic [DAT_BITS-1:0] w;
    int                  n;
    put_inst({SEND_INTERRUPT, 8'(a), idx});
    n = words_of(m_type[a]);
    push_byte(idx[7:0], 1'b1, 1'b0);
    push_byte(idx[15:8], 1'b0, 1'b0);
    push_byte(8'(m_type[a]), 1'b0, 1'b0);
    for (int k = 0; k < n; k++) begin
      w = m_dat[a + k];
      for (int j = 0; j < DAT_BITS / 8; j++)
        push_byte(w[8*j +: 8], 1'b0, k == n - 1 && j == DAT_BITS / 8 - 1);
    end
  endtask

  task automatic add_halt();
    put_inst({NOOP_WAIT, 24'd0});
  endtask

  task automatic run_program(input logic [INST_ADDR_BITS-1:0] pt);
    @(negedge i_clk);
    i_start    = 1'b1;
    i_start_pt = pt;
    started    = 1'b1;
    @(negedge i_clk);
    i_start = 1'b0;
    while (o_busy)
      @(negedge i_clk);
    // Stream may still be draining
    while (rx_idx != n_exp)
      @(negedge i_clk);
  endtask

  task automatic check_slot(input int addr);
    @(negedge i_clk);
    rd_chk      = 1'b0;
    i_slot_addr = SLOT_ADDR_BITS'(addr);
    @(negedge i_clk);
    exp_type = m_type[addr];
    exp_dat  = m_dat[addr];
    rd_chk   = 1'b1;
    @(negedge i_clk);
    rd_chk = 1'b0;
  endtask

  // Random back-pressure on the byte stream
  always @(negedge i_clk) begin
    if (i_rst)
      i_tx_rdy = 1'b0;
    else
      i_tx_rdy = 1'($random(seed));
  end

  always @(posedge i_clk) begin
    if (i_rst)
      rx_idx <= 0;
    else if (o_tx_val && i_tx_rdy)
      rx_idx <= rx_idx + 1;
  end

  a_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    !started |-> !o_busy && !o_tx_val)
    else report_value("idle busy and tx_val", 0, {$sampled(o_busy), $sampled(o_tx_val)});

  a_busy_rise: assert property (@(posedge i_clk) disable iff (i_rst)
    i_start && !o_busy |=> o_busy)
    else report_value("o_busy after start", 1, 0);

  a_slot_type: assert property (@(posedge i_clk) disable iff (i_rst)
    rd_chk |-> o_slot_rtype == exp_type)
    else report_value("slot type", $sampled(exp_type), $sampled(o_slot_rtype));

  a_slot_dat: assert property (@(posedge i_clk) disable iff (i_rst)
    rd_chk |-> o_slot_rdat == exp_dat)
    else report_value("slot data", $sampled(exp_dat), $sampled(o_slot_rdat));

  a_tx_extra: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && i_tx_rdy |-> rx_idx < n_exp)
    else fail_stop("Transmit port sent a byte that no SEND_INTERRUPT produced");

  a_tx_byte: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && i_tx_rdy |-> o_tx_dat == exp_byte)
    else report_value("tx byte", $sampled(exp_byte), $sampled(o_tx_dat));

  a_tx_sop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && i_tx_rdy |-> o_tx_sop == exp_sop)
    else report_value("tx sop", $sampled(exp_sop), $sampled(o_tx_sop));

  a_tx_eop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && i_tx_rdy |-> o_tx_eop == exp_eop)
    else report_value("tx eop", $sampled(exp_eop), $sampled(o_tx_eop));

  a_tx_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && !i_tx_rdy |=>
      o_tx_val && $stable(o_tx_dat) && $stable(o_tx_sop) && $stable(o_tx_eop))
    else fail_stop("Transmit outputs changed while i_tx_rdy was low");

  initial begin
    #((N_PROGS * PROG_BOUND + 20) * CLK_PERIOD);
    fail_stop("Watchdog timeout, a program or its byte stream never finished");
  end

  initial begin
    i_rst        = 1'b1;
    i_inst_we    = 1'b0;
    i_inst_addr  = '0;
    i_inst_wdat  = '0;
    i_slot_we    = 1'b0;
    i_slot_addr  = '0;
    i_slot_wtype = SCALAR;
    i_slot_wdat  = '0;
    i_start      = 1'b0;
    i_start_pt   = '0;
    rd_chk       = 1'b0;
    started      = 1'b0;
    n_exp        = 0;
    pc           = '0;
    test_name    = "reset";
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    repeat (8) @(negedge i_clk);

    test_name = "copy";
    write_slot(10, rand_type(), rand_elem());
    write_slot(11, rand_type(), rand_elem());
    pc = 8'd0;
    add_copy(10, 20);
    add_copy(11, 21);
    add_halt();
    run_program(8'd0);
    check_slot(20);
    check_slot(21);
    check_slot(10);

    test_name = "mul";
    for (int s = 30; s < 38; s++)
      write_slot(s, rand_type(), rand_elem());
    pc = 8'd16;
    // Independent products back to back, then a dependent chain
    add_mul(30, 31, 40);
    add_mul(32, 33, 41);
    add_mul(34, 35, 42);
    add_mul(36, 37, 43);
    add_mul(40, 41, 44);
    add_mul(44, 30, 45);
    add_halt();
    run_program(8'd16);
    for (int s = 40; s < 46; s++)
      check_slot(s);

    test_name = "irq";
    write_slot(50, FE, rand_elem());
    write_slot(52, FE2, rand_elem());
    write_slot(53, FE2, rand_elem());
    write_slot(56, FE2, rand_elem());
    write_slot(57, FE2, rand_elem());
    pc = 8'd32;
    // Enough entries to fill the interrupt FIFO under back-pressure
    add_send(50, 16'($random(seed)));
    add_send(52, 16'($random(seed)));
    add_send(56, 16'($random(seed)));
    add_send(50, 16'($random(seed)));
    for (int k = 0; k < 3; k++) begin
      add_send(52, 16'($random(seed)));
      add_send(56, 16'($random(seed)));
    end
    add_halt();
    run_program(8'd32);

    test_name = "restart";
    write_slot(60, rand_type(), rand_elem());
    write_slot(61, rand_type(), rand_elem());
    pc = 8'd100;
    add_mul(60, 61, 62);
    add_copy(62, 63);
    add_send(63, 16'($random(seed)));
    add_halt();
    run_program(8'd100);
    check_slot(62);
    check_slot(63);

    test_name = "end";
    repeat (4) @(negedge i_clk);
    if (rx_idx != n_exp)
      report_value("received byte count", n_exp, rx_idx);
    else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* coproc_top.f */
design/coproc_pkg.sv
design/inst_fetch.sv
design/slot_ram.sv
design/inst_exec.sv
design/mod_mult.sv
design/irq_tx.sv
design/coproc_top.sv
testbench/tb_coproc.sv

/* run.sh */
#!/bin/sh
# Build the coprocessor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_coproc -f coproc_top.f
out=$(./obj_dir/Vtb_coproc 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed!"
